/* oscilloscopeCore.f */
verilog/scopePkg.sv
verilog/sampleDecimator.sv
verilog/channelTrigger.sv
verilog/triggerCombiner.sv
verilog/acquisitionControl.sv
verilog/oscilloscopeCore.sv
verification/oscilloscopeCoreTb.sv

/* verification/oscilloscopeCoreTb.sv */
`timescale 1ns/1ps

module oscilloscopeCoreTb;

	localparam logic [7:0] IN_LEVEL  = 8'ha0; // inside the 80..bf window
	localparam logic [7:0] OUT_LEVEL = 8'h20; // below the window
	localparam logic [7:0] HR_LEVEL  = 8'h5a; // constant fed through the averager
	localparam int TRIG_LIMIT = 40;           // stimulus to triggered, ext delay included
	// rough cycle budget of scenarios 1 to 6
	localparam int SCENARIO_CYCLES = 60 + 60 + 140 + 60 + 220 + 170;
	localparam int TIMEOUT_CYCLES  = 6 * SCENARIO_CYCLES;

	logic                     clk_flash;
	logic                     rst;
	scopePkg::sampleSet_t     adcData;
	scopePkg::triggerConfig_t trigConfig;
	scopePkg::acqConfig_t     acqConfig;
	logic                     startAcq;
	logic                     extTrig;
	logic                     useExtTrig;
	logic                     isFirst;
	logic                     isLast;
	logic [1:0]               trigIn;
	logic [1:0]               trigOut;
	scopePkg::sampleWrite_t   sampleWrite;
	scopePkg::acqStatus_t     status;

	logic [31:0]       rngState;
	logic [3:0]        forced; // channels held at a set level, the rest get noise
	scopePkg::sample_t level [scopePkg::NUM_CHANNELS];
	logic              quiet;     // no trigger may show up
	logic              awaitTrig; // a trigger is due soon
	logic              hrSettled; // averaging window full of HR_LEVEL
	int                trigWait;
	int                cycleCount;
	int                gap;         // cycles since the last write
	int                postWrites;  // writes while triggered
	int                preWrites;   // writes ahead of the trigger
	logic              havePrev;
	logic              prevTrig;    // triggered flag of the previous write
	scopePkg::addr_t   lastPreAddr;
	scopePkg::addr_t   expectedPost;

	oscilloscopeCore DUT (.*);

	assign expectedPost = acqConfig.nSamples - acqConfig.triggerPoint;

	initial begin
		clk_flash = 1'b0;
		forever #4 clk_flash = ~clk_flash;
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk_flash);
	endtask

	task automatic holdChannel(input int ch, input scopePkg::sample_t value);
		forced[ch] <= 1'b1;
		level[ch]  <= value;
	endtask

	task automatic setTrigger(input logic [3:0] enable, input logic rising, input int tot);
		trigConfig <= '{lowThreshold: 8'h80, highThreshold: 8'hbf, channelEnable: enable,
			risingEdge: rising, totOnDecimated: 1'b0, totCount: 10'(tot)};
	endtask

	task automatic configureAcq(input logic [4:0] ds, input logic hr);
		acqConfig <= '{triggerPoint: 10'd4, nSamples: 10'd12, downsample: ds, highres: hr};
	endtask

	// one startAcq pulse, returns straight away
	task automatic pulseStart();
		@(posedge clk_flash);
		startAcq <= 1'b1;
		@(posedge clk_flash);
		startAcq <= 1'b0;
	endtask

	// returns once the pre-trigger history is written and triggers count
	task automatic startCapture();
		pulseStart();
		do @(negedge clk_flash); while (preWrites < acqConfig.triggerPoint + 2);
		@(posedge clk_flash);
	endtask

	task automatic finishCapture();
		do @(negedge clk_flash); while (!status.triggered);
		@(posedge clk_flash);
		awaitTrig <= 1'b0;
		do @(negedge clk_flash); while (!status.dataReady);
		@(posedge clk_flash);
	endtask

	// noise stays below the window so only held channels can trigger
	always @(posedge clk_flash) begin
		rngState <= nextRandom(rngState);
		for (int c = 0; c < scopePkg::NUM_CHANNELS; c++) begin
			adcData.channel[c] <= forced[c] ? level[c] : {1'b0, rngState[8*c +: 7]};
		end
	end

	// reference counters, cleared when a capture starts
	always @(posedge clk_flash) begin
		if (rst || startAcq) begin
			postWrites <= 0;
			preWrites  <= 0;
			havePrev   <= 1'b0;
			gap        <= 0;
		end else begin
			gap <= gap + 1;
			if (sampleWrite.valid) begin
				gap      <= 1;
				havePrev <= 1'b1;
				prevTrig <= status.triggered;
				if (status.triggered) begin
					postWrites <= postWrites + 1;
				end else begin
					preWrites   <= preWrites + 1;
					lastPreAddr <= sampleWrite.address; // last one before triggered
				end
			end
		end
	end

	always @(posedge clk_flash) begin
		cycleCount <= cycleCount + 1;
		trigWait   <= (awaitTrig && !status.triggered) ? trigWait + 1 : 0;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			failRun($sformatf("timeout after %0d cycles, the scenarios never finished",
				cycleCount));
		end
	end

	assert property (@(posedge clk_flash) disable iff (rst)
		$fell(rst) |-> (trigOut == 2'b00) && !sampleWrite.valid && !status.acquiring &&
			!status.triggered && !status.dataReady)
		else failRun("outputs were not low right after reset");
	assert property (@(posedge clk_flash) disable iff (rst)
		$rose(status.dataReady) |-> postWrites == expectedPost)
		else failRun($sformatf("FAILED postWrites: got %h expected %h",
			$sampled(postWrites), $sampled(expectedPost)));
	assert property (@(posedge clk_flash) disable iff (rst)
		$rose(status.dataReady) |-> preWrites >= acqConfig.triggerPoint)
		else failRun($sformatf("FAILED preWrites: got %h expected at least %h",
			$sampled(preWrites), $sampled(acqConfig.triggerPoint)));
	assert property (@(posedge clk_flash) disable iff (rst)
		$rose(status.dataReady) |-> status.triggerAddress == lastPreAddr)
		else failRun($sformatf("FAILED status.triggerAddress: got %h expected %h",
			$sampled(status.triggerAddress), $sampled(lastPreAddr)));
	assert property (@(posedge clk_flash) disable iff (rst)
		quiet |-> (trigOut == 2'b00) && !status.triggered)
		else failRun($sformatf("trigger showed up where none was allowed, trigOut %h",
			$sampled(trigOut)));
	assert property (@(posedge clk_flash) disable iff (rst) trigWait <= TRIG_LIMIT)
		else failRun($sformatf("no trigger within %0d cycles of the stimulus", TRIG_LIMIT));
	assert property (@(posedge clk_flash) disable iff (rst)
		trigIn[0] && !isFirst |=> trigOut[0])
		else failRun("trigIn[0] did not reach trigOut[0] one cycle later");
	assert property (@(posedge clk_flash) disable iff (rst)
		sampleWrite.valid && havePrev && (prevTrig == status.triggered) |->
			gap == (1 << acqConfig.downsample))
		else failRun($sformatf("FAILED write spacing: got %h expected %h",
			$sampled(gap), 1 << $sampled(acqConfig.downsample)));
	assert property (@(posedge clk_flash) disable iff (rst)
		hrSettled && sampleWrite.valid |-> sampleWrite.samples == {4{HR_LEVEL}})
		else failRun($sformatf("FAILED sampleWrite.samples: got %h expected %h",
			$sampled(sampleWrite.samples), {4{HR_LEVEL}}));

	initial begin
		rst        = 1'b1;
		adcData    = '0;
		trigConfig = '0;
		acqConfig  = '0;
		startAcq   = 1'b0;
		extTrig    = 1'b0;
		useExtTrig = 1'b0;
		isFirst    = 1'b0;
		isLast     = 1'b0;
		trigIn     = 2'b00;
		rngState   = 32'h1f16_f702;
		forced     = '0;
		for (int c = 0; c < scopePkg::NUM_CHANNELS; c++) begin
			level[c] = OUT_LEVEL;
		end
		quiet      = 1'b0;
		awaitTrig  = 1'b0;
		hrSettled  = 1'b0;
		trigWait   = 0;
		cycleCount = 0;
		repeat (5) @(posedge clk_flash);
		rst <= 1'b0;
		setTrigger(4'b0001, 1'b1, 0);
		configureAcq(5'd0, 1'b0);

		// rising edge on channel 0
		startCapture();
		awaitTrig <= 1'b1;
		holdChannel(0, IN_LEVEL);
		idle(4);
		holdChannel(0, OUT_LEVEL);
		finishCapture();

		// channel 2 edge while only channel 0 is enabled, then enable it
		startCapture();
		quiet <= 1'b1;
		holdChannel(2, IN_LEVEL);
		idle(4);
		holdChannel(2, OUT_LEVEL);
		idle(16);
		quiet <= 1'b0;
		trigConfig.channelEnable <= 4'b0100;
		awaitTrig <= 1'b1;
		holdChannel(2, IN_LEVEL);
		idle(4);
		holdChannel(2, OUT_LEVEL);
		finishCapture();

		// time over threshold of 6, short pulse then long pulse
		setTrigger(4'b0001, 1'b1, 6);
		startCapture();
		quiet <= 1'b1;
		holdChannel(0, IN_LEVEL);
		idle(3);
		holdChannel(0, OUT_LEVEL);
		idle(16);
		quiet <= 1'b0;
		awaitTrig <= 1'b1;
		holdChannel(0, IN_LEVEL);
		idle(12);
		holdChannel(0, OUT_LEVEL);
		finishCapture();

		// falling edge, entering the window must not fire
		setTrigger(4'b0001, 1'b0, 0);
		startCapture();
		quiet <= 1'b1;
		holdChannel(0, IN_LEVEL);
		idle(16);
		quiet <= 1'b0;
		awaitTrig <= 1'b1;
		holdChannel(0, OUT_LEVEL);
		finishCapture();

		// daisy chain where a lone board drops trigIn[0]
		setTrigger(4'b0001, 1'b1, 0);
		isFirst <= 1'b1;
		isLast  <= 1'b1; // no neighbour on either side
		startCapture();
		quiet  <= 1'b1;
		trigIn <= 2'b01;
		idle(1);
		trigIn <= 2'b00;
		idle(10);
		quiet   <= 1'b0;
		isFirst <= 1'b0;
		isLast  <= 1'b0;
		awaitTrig <= 1'b1;
		trigIn    <= 2'b01;
		idle(1);
		trigIn <= 2'b00;
		finishCapture();

		// decimate by 8 with averaging while a chain trigger waits out the pre-trigger fill
		configureAcq(5'd3, 1'b1);
		forced <= 4'b1111;
		for (int c = 0; c < scopePkg::NUM_CHANNELS; c++) begin
			level[c] <= HR_LEVEL;
		end
		idle(40); // a few full windows
		hrSettled <= 1'b1;
		trigIn    <= 2'b01; // held from the start so only the waiting state takes it
		pulseStart();
		do @(negedge clk_flash); while (!status.triggered);
		@(posedge clk_flash);
		trigIn <= 2'b00;
		finishCapture();
		hrSettled <= 1'b0;
		forced    <= '0;

		// external trigger, ignored first and then used
		configureAcq(5'd3, 1'b0);
		useExtTrig <= 1'b0;
		startCapture();
		quiet   <= 1'b1;
		extTrig <= 1'b1;
		idle(1);
		extTrig <= 1'b0;
		idle(30); // well past the delay line
		quiet      <= 1'b0;
		useExtTrig <= 1'b1;
		awaitTrig  <= 1'b1;
		extTrig    <= 1'b1;
		idle(1);
		extTrig <= 1'b0;
		finishCapture();

		$display("TEST PASS");
		$finish;
	end

endmodule

/* verilog/oscilloscopeCore.sv */
`timescale 1ns/1ps

module oscilloscopeCore (
	input  logic                     clk_flash,
	input  logic                     rst,
	input  scopePkg::sampleSet_t     adcData,
	input  scopePkg::triggerConfig_t trigConfig,
	input  scopePkg::acqConfig_t     acqConfig,
	input  logic                     startAcq,
	input  logic                     extTrig,
	input  logic                     useExtTrig,
	input  logic                     isFirst,
	input  logic                     isLast,
	input  logic [1:0]               trigIn,
	output logic [1:0]               trigOut,
	output scopePkg::sampleWrite_t   sampleWrite,
	output scopePkg::acqStatus_t     status
);

	scopePkg::sampleSet_t              regSamples; // raw samples after the pin flop
	scopePkg::sampleSet_t              avgSamples; // decimated or averaged samples
	logic                              decimateGo;
	logic [scopePkg::NUM_CHANNELS-1:0] fire;       // per-channel trigger pulses
	logic                              trigger;    // combined trigger to the controller

	sampleDecimator decimator (
		.clk_flash  (clk_flash),
		.rst        (rst),
		.adcData    (adcData),
		.downsample (acqConfig.downsample),
		.highres    (acqConfig.highres),
		.regSamples (regSamples),
		.avgSamples (avgSamples),
		.decimateGo (decimateGo)
	);

	// triggers look at every raw sample, not the decimated stream
	for (genvar ch = 0; ch < scopePkg::NUM_CHANNELS; ch++) begin : chanTrig
		channelTrigger trig (
			.clk_flash  (clk_flash),
			.rst        (rst),
			.sample     (regSamples.channel[ch]),
			.trigConfig (trigConfig),
			.decimateGo (decimateGo),
			.fire       (fire[ch])
		);
	end

	triggerCombiner combiner (
		.clk_flash     (clk_flash),
		.rst           (rst),
		.fire          (fire),
		.channelEnable (trigConfig.channelEnable),
		.extTrig       (extTrig),
		.useExtTrig    (useExtTrig),
		.isFirst       (isFirst),
		.isLast        (isLast),
		.trigIn        (trigIn),
		.trigOut       (trigOut),
		.trigger       (trigger)
	);

	acquisitionControl control (
		.clk_flash    (clk_flash),
		.rst          (rst),
		.startAcq     (startAcq),
		.trigger      (trigger),
		.decimateGo   (decimateGo),
		.avgSamples   (avgSamples),
		.triggerPoint (acqConfig.triggerPoint),
		.nSamples     (acqConfig.nSamples),
		.sampleWrite  (sampleWrite),
		.status       (status)
	);

endmodule

/* verilog/acquisitionControl.sv */
`timescale 1ns/1ps

module acquisitionControl (
	input  logic                   clk_flash,
	input  logic                   rst,
	input  logic                   startAcq,
	input  logic                   trigger,
	input  logic                   decimateGo,
	input  scopePkg::sampleSet_t   avgSamples,
	input  scopePkg::addr_t        triggerPoint,
	input  scopePkg::addr_t        nSamples,
	output scopePkg::sampleWrite_t sampleWrite,
	output scopePkg::acqStatus_t   status
);

	typedef enum logic [1:0] {IDLE, PREACQ, WAITING, POSTACQ} acqState_t;

	acqState_t            state;
	scopePkg::addr_t      sampleCount;    // writes in the current phase
	scopePkg::addr_t      postTarget;     // writes owed after the trigger
	scopePkg::addr_t      nextAddr;       // circular write pointer
	scopePkg::addr_t      writeAddress;
	scopePkg::addr_t      triggerAddress;
	scopePkg::sampleSet_t writeSamples;
	logic writeNow;
	logic writeValid;
	logic acquiring;
	logic triggered;
	logic dataReady;

	assign postTarget = nSamples - triggerPoint;

	always_comb begin
		case (state)
			PREACQ:  writeNow = decimateGo;
			WAITING: writeNow = decimateGo & ~trigger; // trigger edge itself writes nothing
			POSTACQ: writeNow = decimateGo && (sampleCount != postTarget);
			default: writeNow = 1'b0;
		endcase
	end

	always_ff @(posedge clk_flash) begin
		if (rst) begin
			state       <= IDLE;
			sampleCount <= '0;
			nextAddr    <= '0;
			writeValid  <= 1'b0;
			acquiring   <= 1'b0;
			triggered   <= 1'b0;
			dataReady   <= 1'b0;
		end else begin
			writeValid <= writeNow;
			if (writeNow) begin
				nextAddr <= nextAddr + 1'b1;
			end
			case (state)
				IDLE: begin
					if (startAcq) begin
						state       <= PREACQ;
						acquiring   <= 1'b1;
						dataReady   <= 1'b0; // old capture is about to be overwritten
						sampleCount <= '0;
					end
				end
				PREACQ: begin
					if (sampleCount == triggerPoint) begin
						state       <= WAITING; // pre-trigger history is in memory
						sampleCount <= '0;
					end else if (writeNow) begin
						sampleCount <= sampleCount + 1'b1;
					end
				end
				WAITING: begin
					if (trigger) begin
						state     <= POSTACQ;
						triggered <= 1'b1;
					end
				end
				POSTACQ: begin
					if (sampleCount == postTarget) begin
						state     <= IDLE;
						acquiring <= 1'b0;
						triggered <= 1'b0;
						dataReady <= 1'b1;
					end else if (writeNow) begin
						sampleCount <= sampleCount + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_flash) begin
		if (writeNow) begin
			writeAddress <= nextAddr;
			writeSamples <= avgSamples;
		end
		if ((state == WAITING) && trigger) begin
			triggerAddress <= writeAddress; // last write before triggered rises
		end
	end

	assign sampleWrite = '{valid: writeValid, address: writeAddress, samples: writeSamples};
	assign status = '{acquiring: acquiring, triggered: triggered, dataReady: dataReady,
		triggerAddress: triggerAddress};

	assert property (@(posedge clk_flash) disable iff (rst) sampleWrite.valid |-> status.acquiring)
		else $error("write at %h outside a capture", sampleWrite.address);
	assert property (@(posedge clk_flash) disable iff (rst)
		!(status.dataReady && status.acquiring))
		else $error("dataReady and acquiring both high");

endmodule

/* verilog/triggerCombiner.sv */
`timescale 1ns/1ps

module triggerCombiner (
	input  logic                              clk_flash,
	input  logic                              rst,
	input  logic [scopePkg::NUM_CHANNELS-1:0] fire,
	input  logic [scopePkg::NUM_CHANNELS-1:0] channelEnable,
	input  logic                              extTrig,
	input  logic                              useExtTrig,
	input  logic                              isFirst,
	input  logic                              isLast,
	input  logic [1:0]                        trigIn,
	output logic [1:0]                        trigOut,
	output logic                              trigger
);

	logic [scopePkg::EXT_TRIG_DELAY-1:0] extDelay; // shift line for the external input
	logic selfTrig;  // this board's own trigger
	logic passLeft;  // chain trigger travelling left
	logic passRight; // chain trigger travelling right

	always_ff @(posedge clk_flash) begin
		if (rst) begin
			extDelay <= '0;
		end else begin
			extDelay <= {extDelay[scopePkg::EXT_TRIG_DELAY-2:0], extTrig};
		end
	end

	assign selfTrig  = (|(fire & channelEnable)) |
		(useExtTrig & extDelay[scopePkg::EXT_TRIG_DELAY-1]);
	assign passLeft  = trigIn[0] & ~isFirst; // leftmost board ends the left-going chain
	assign passRight = trigIn[1] & ~isLast;  // rightmost board ends the right-going chain

	always_ff @(posedge clk_flash) begin
		if (rst) begin
			trigger <= 1'b0;
			trigOut <= 2'b00;
		end else begin
			trigger    <= selfTrig | (trigIn[0] & ~isLast) | // nothing comes from right of the last
				(trigIn[1] & ~isFirst);                      // nor from left of the first
			trigOut[0] <= selfTrig | passLeft;  // towards the left neighbour
			trigOut[1] <= selfTrig | passRight; // towards the right neighbour
		end
	end

endmodule

/* verilog/channelTrigger.sv */
`timescale 1ns/1ps

module channelTrigger (
	input  logic                     clk_flash,
	input  logic                     rst,
	input  scopePkg::sample_t        sample,
	input  scopePkg::triggerConfig_t trigConfig,
	input  logic                     decimateGo,
	output logic                     fire
);

	logic inWindow;   // registered window compare
	logic prevWindow; // window state one cycle back
	logic edgeSeen;   // change in the selected direction
	logic levelHeld;  // still on the post-edge side
	logic totAdvance; // counter may step this cycle
	logic [scopePkg::ADDR_WIDTH:0] totCounter; // one bit wider so it can pass totCount

	always_ff @(posedge clk_flash) begin
		if (rst) begin
			inWindow   <= 1'b0;
			prevWindow <= 1'b0;
		end else begin
			inWindow   <= (sample >= trigConfig.lowThreshold) &&
				(sample <= trigConfig.highThreshold);
			prevWindow <= inWindow;
		end
	end

	always_comb begin
		if (trigConfig.risingEdge) begin
			edgeSeen  = inWindow & ~prevWindow; // entered the window
			levelHeld = inWindow;
		end else begin
			edgeSeen  = ~inWindow & prevWindow; // dropped out of the window
			levelHeld = ~inWindow;
		end
		totAdvance = ~trigConfig.totOnDecimated | decimateGo;
	end

	always_ff @(posedge clk_flash) begin
		if (rst) begin
			fire       <= 1'b0;
			totCounter <= '0;
		end else if (trigConfig.totCount == '0) begin
			fire       <= edgeSeen; // plain edge trigger
			totCounter <= '0;
		end else if (totCounter != '0) begin
			fire <= 1'b0;
			if (totCounter > {1'b0, trigConfig.totCount}) begin
				fire       <= 1'b1; // held long enough
				totCounter <= '0;   // one pulse per qualified edge
			end else if (totAdvance) begin
				if (levelHeld) begin
					totCounter <= totCounter + 1'b1;
				end else begin
					totCounter <= '0; // level broke, give up
				end
			end
		end else begin
			fire <= 1'b0;
			if (edgeSeen) begin
				totCounter <= 1; // edge arms the counter
			end
		end
	end

	// the counter restarts after firing so a second pulse needs a new edge
	assert property (@(posedge clk_flash) disable iff (rst)
		(trigConfig.totCount != '0) && fire |=> !fire)
		else $error("fire high two cycles running with totCount %0d", trigConfig.totCount);

endmodule

/* verilog/sampleDecimator.sv */
`timescale 1ns/1ps

module sampleDecimator (
	input  logic                 clk_flash,
	input  logic                 rst,
	input  scopePkg::sampleSet_t adcData,
	input  logic [4:0]           downsample,
	input  logic                 highres,
	output scopePkg::sampleSet_t regSamples,
	output scopePkg::sampleSet_t avgSamples,
	output logic                 decimateGo
);

	logic [31:0] decCount;  // free-running phase inside the window
	logic [31:0] lastCount; // final phase of a window
	logic        hrMode;
	logic        hrDump;
	logic [4:0]  hrShift;
	logic [scopePkg::MAX_HIGHRES-1:0] hrCount; // samples summed so far, minus one
	logic [scopePkg::NUM_CHANNELS-1:0][scopePkg::SAMPLE_WIDTH+scopePkg::MAX_HIGHRES-1:0] accSum;
	logic [scopePkg::NUM_CHANNELS-1:0][scopePkg::SAMPLE_WIDTH+scopePkg::MAX_HIGHRES-1:0] sumNext;
	scopePkg::sampleSet_t maxSeen; // per-channel peak since reset

	always_ff @(posedge clk_flash) begin
		regSamples <= adcData; // first flop on the ADC pins
	end

	assign lastCount  = (32'd1 << downsample) - 32'd1;
	assign decimateGo = decCount >= lastCount; // downsample 0 strobes every cycle
	assign hrMode     = highres && (downsample != 5'd0);
	assign hrDump     = decimateGo || (&hrCount); // early dump once 32 samples are in
	assign hrShift    = (downsample > 5'(scopePkg::MAX_HIGHRES)) ?
		5'(scopePkg::MAX_HIGHRES) : downsample;

	always_comb begin
		for (int c = 0; c < scopePkg::NUM_CHANNELS; c++) begin
			sumNext[c] = accSum[c] + regSamples.channel[c]; // includes this cycle's sample
		end
	end

	always_ff @(posedge clk_flash) begin
		if (rst) begin
			decCount <= '0;
		end else begin
			decCount <= decimateGo ? '0 : decCount + 32'd1; // wraps on each strobe
		end
	end

	always_ff @(posedge clk_flash) begin
		if (rst || !hrMode || hrDump) begin
			accSum  <= '0; // start a fresh window
			hrCount <= '0;
		end else begin
			accSum  <= sumNext;
			hrCount <= hrCount + 1'b1;
		end
	end

	always_ff @(posedge clk_flash) begin
		if (rst) begin
			avgSamples <= '0;
		end else if (!hrMode) begin
			avgSamples <= regSamples; // plain decimation path
		end else if (hrDump) begin
			for (int c = 0; c < scopePkg::NUM_CHANNELS; c++) begin
				avgSamples.channel[c] <= scopePkg::sample_t'(sumNext[c] >> hrShift);
			end
		end
	end

	always_ff @(posedge clk_flash) begin
		if (rst) begin
			maxSeen <= '0;
		end else begin
			for (int c = 0; c < scopePkg::NUM_CHANNELS; c++) begin
				if (regSamples.channel[c] > maxSeen.channel[c]) begin
					maxSeen.channel[c] <= regSamples.channel[c];
				end
			end
		end
	end

	// an average can never climb above the samples that went into it
	for (genvar c = 0; c < scopePkg::NUM_CHANNELS; c++) begin : avgBound
		assert property (@(posedge clk_flash) disable iff (rst)
			avgSamples.channel[c] <= maxSeen.channel[c])
			else $error("avgSamples channel %0d above input peak", c);
	end

endmodule

/* verilog/scopePkg.sv */
package scopePkg;

	localparam int NUM_CHANNELS   = 4;  // flash ADC channels per board
	localparam int SAMPLE_WIDTH   = 8;  // bits per ADC sample
	localparam int ADDR_WIDTH     = 10; // sample memory depth is 2^10
	localparam int MAX_HIGHRES    = 5;  // averaging never goes past 32 samples
	localparam int EXT_TRIG_DELAY = 13; // external trigger lines up with channel triggers

	typedef logic [SAMPLE_WIDTH-1:0] sample_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t; // memory address or sample count

	typedef struct packed {
		sample_t [NUM_CHANNELS-1:0] channel; // channel 0 in the low byte
	} sampleSet_t;

	typedef struct packed {
		sample_t lowThreshold;                // bottom of the trigger window
		sample_t highThreshold;               // top of the trigger window
		logic [NUM_CHANNELS-1:0] channelEnable; // channels allowed to self-trigger
		logic risingEdge;                     // 1 fires entering the window, 0 leaving it
		logic totOnDecimated;                 // count time-over-threshold on strobes only
		logic [ADDR_WIDTH-1:0] totCount;      // zero fires straight on the edge
	} triggerConfig_t;

	typedef struct packed {
		addr_t triggerPoint;     // samples kept ahead of the trigger
		addr_t nSamples;         // total samples in a capture
		logic [4:0] downsample;  // keep one sample in 2^downsample
		logic highres;           // average inside the decimation window
	} acqConfig_t;

	typedef struct packed {
		logic valid;             // taken by the memory on the same edge
		addr_t address;
		sampleSet_t samples;
	} sampleWrite_t;

	typedef struct packed {
		logic acquiring;         // capture in progress
		logic triggered;         // post-trigger part of the capture
		logic dataReady;         // capture done and memory holds it
		addr_t triggerAddress;   // last pre-trigger write address
	} acqStatus_t;

endpackage
